// File: source/adv_cfg_pkg.sv
package adv_cfg_pkg;

    // register address and data on the chip's I2C port
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // 7 bit device address on the bus
    typedef logic [6:0] chip_addr_t;

    // index of a write within one phase
    typedef logic [5:0] step_t;

    // PLL lock failures, wraps at 255
    typedef logic [7:0] err_count_t;

    // command phases of the setup sequence
    typedef enum logic [1:0] {
        PH_BOOTSTRAP,
        PH_INIT,
        PH_PLL_CHECK,
        PH_DONE
    } phase_t;

    // per-transfer handshake states
    typedef enum logic [1:0] {
        XS_START,
        XS_WAIT,
        XS_WAIT_2,
        XS_IDLE
    } xfer_state_t;

    localparam int BOOTSTRAP_STEPS = 11;
    localparam int INIT_STEPS      = 16;

    // PLL status lives in the main map
    localparam reg_addr_t PLL_STATUS_REG = 8'h9E;
    localparam int        PLL_LOCK_BIT   = 4;

endpackage

// File: source/i2c_req_if.sv
`timescale 1ns/1ps

interface i2c_req_if;

    // request side
    logic                   issue;
    logic                   is_read;
    adv_cfg_pkg::reg_addr_t reg_addr;
    adv_cfg_pkg::reg_data_t value;

    // response side
    logic                   complete;
    logic                   ack_error;
    adv_cfg_pkg::reg_data_t rdata;

    modport seq (
        output issue, is_read, reg_addr, value,
        input  complete, ack_error, rdata
    );

    modport port (
        input  issue, is_read, reg_addr, value,
        output complete, ack_error, rdata
    );

endinterface

// File: source/adv_reg_table.sv
`timescale 1ns/1ps

module adv_reg_table #(
    parameter bit OUTPUT_FMT_422 = 1'b0
) (
    input  adv_cfg_pkg::phase_t    phase,
    input  adv_cfg_pkg::step_t     step,
    input  adv_cfg_pkg::reg_data_t reg_17,
    input  adv_cfg_pkg::reg_data_t reg_3b,
    input  adv_cfg_pkg::reg_data_t reg_3c,
    output adv_cfg_pkg::reg_addr_t entry_addr,
    output adv_cfg_pkg::reg_data_t entry_value,
    output logic                   entry_last
);

    // address in the upper byte, value in the lower byte
    logic [15:0] entry;

    always_comb begin
        entry = 16'h0000;
        case (phase)
            adv_cfg_pkg::PH_BOOTSTRAP: begin
                case (step)
                    // all circuits powered up, sync adjust off
                    6'd0:  entry = 16'h41_10;
                    // fixed registers required after power up
                    6'd1:  entry = 16'h98_03;
                    6'd2:  entry = 16'h9A_E0;
                    6'd3:  entry = 16'h9C_30;
                    6'd4:  entry = 16'h9D_01;
                    6'd5:  entry = 16'hA2_A4;
                    6'd6:  entry = 16'hA3_A4;
                    6'd7:  entry = 16'hE0_D0;
                    6'd8:  entry = 16'hF9_00;
                    // enable HPD and monitor sense interrupts
                    6'd9:  entry = 16'h94_C0;
                    // and clear whatever is pending
                    6'd10: entry = 16'h96_C0;
                    default: entry = 16'h0000;
                endcase
            end
            adv_cfg_pkg::PH_INIT: begin
                case (step)
                    // 44.1 kHz i2s, 24 bit RGB 4:4:4 input
                    6'd0:  entry = 16'h15_00;
                    6'd1:  entry = {8'h17, reg_17};
                    // 8 bit colour depth, 4:2:2 YCbCr output when selected
                    6'd2:  entry = {8'h16, 8'h30 | (OUTPUT_FMT_422 ? 8'h81 : 8'h00)};
                    6'd3:  entry = 16'h55_00;
                    // CSC off
                    6'd4:  entry = 16'h18_46;
                    // HDMI mode, no HDCP
                    6'd5:  entry = 16'hAF_06;
                    6'd6:  entry = 16'hBA_60;
                    // automatic CTS, i2s audio, 128xfs
                    6'd7:  entry = 16'h0A_00;
                    // N = 0x01880 for 44.1 kHz
                    6'd8:  entry = 16'h01_00;
                    6'd9:  entry = 16'h02_18;
                    6'd10: entry = 16'h03_80;
                    6'd11: entry = 16'h0B_0E;
                    // i2s0 only, right justified, 16 bit
                    6'd12: entry = 16'h0C_05;
                    6'd13: entry = 16'h0D_10;
                    // pixel repetition and VIC from the video mode
                    6'd14: entry = {8'h3B, reg_3b};
                    6'd15: entry = {8'h3C, reg_3c};
                    default: entry = 16'h0000;
                endcase
            end
            default: entry = 16'h0000;
        endcase
    end

    assign entry_addr  = entry[15:8];
    assign entry_value = entry[7:0];

    assign entry_last =
        ((phase == adv_cfg_pkg::PH_BOOTSTRAP) &&
         (step == adv_cfg_pkg::step_t'(adv_cfg_pkg::BOOTSTRAP_STEPS - 1))) ||
        ((phase == adv_cfg_pkg::PH_INIT) &&
         (step == adv_cfg_pkg::step_t'(adv_cfg_pkg::INIT_STEPS - 1)));

endmodule

// File: source/step_counter.sv
`timescale 1ns/1ps

module step_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    step_advance,
    input  logic                    step_clear,
    input  logic                    pll_fail,
    output adv_cfg_pkg::step_t      step,
    output adv_cfg_pkg::err_count_t pll_fail_count
);

    always_ff @(posedge clk) begin
        if (!reset) begin
            step           <= '0;
            pll_fail_count <= '0;
        end else begin
            // a clear always wins over an advance
            if (step_clear) begin
                step <= '0;
            end else if (step_advance) begin
                step <= step + 1'b1;
            end

            if (pll_fail) begin
                pll_fail_count <= pll_fail_count + 1'b1;
            end
        end
    end

endmodule

// File: source/adv_cfg_fsm.sv
`timescale 1ns/1ps

module adv_cfg_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hdmi_int,
    output adv_cfg_pkg::phase_t    phase,
    input  adv_cfg_pkg::step_t     step,
    output logic                   step_advance,
    output logic                   step_clear,
    output logic                   pll_fail,
    input  adv_cfg_pkg::reg_addr_t entry_addr,
    input  adv_cfg_pkg::reg_data_t entry_value,
    input  logic                   entry_last,
    i2c_req_if.seq                 req,
    output logic                   ready
);

    adv_cfg_pkg::xfer_state_t state;

    logic hdmi_int_prev;
    logic hdmi_int_pend;
    logic hdmi_int_fall;

    logic table_phase;
    logic pll_phase;
    logic issue_now;
    logic xfer_ok;
    logic pll_locked;
    logic restart_req;

    // hot plug shows up as a falling edge on the interrupt line
    assign hdmi_int_fall = hdmi_int_prev && !hdmi_int;

    assign table_phase = (phase == adv_cfg_pkg::PH_BOOTSTRAP) ||
                         (phase == adv_cfg_pkg::PH_INIT);
    assign pll_phase   = (phase == adv_cfg_pkg::PH_PLL_CHECK);

    assign issue_now = (state == adv_cfg_pkg::XS_START) && (pll_phase || table_phase);

    assign xfer_ok     = (state == adv_cfg_pkg::XS_WAIT_2) && req.complete && !req.ack_error;
    assign pll_locked  = req.rdata[adv_cfg_pkg::PLL_LOCK_BIT];
    assign restart_req = (state == adv_cfg_pkg::XS_IDLE) && hdmi_int_pend;

    // step control takes effect at the complete edge, before the next lookup
    assign step_advance = xfer_ok && table_phase && !entry_last;
    assign step_clear   = (xfer_ok && (entry_last || pll_phase)) || restart_req;
    assign pll_fail     = xfer_ok && pll_phase && !pll_locked;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= adv_cfg_pkg::XS_START;
            phase         <= adv_cfg_pkg::PH_BOOTSTRAP;
            req.issue     <= 1'b0;
            ready         <= 1'b0;
            hdmi_int_prev <= 1'b1;
            hdmi_int_pend <= 1'b0;
        end else begin
            req.issue     <= issue_now;
            hdmi_int_prev <= hdmi_int;

            case (state)
                adv_cfg_pkg::XS_START: begin
                    if (issue_now) begin
                        state <= adv_cfg_pkg::XS_WAIT;
                    end
                end
                adv_cfg_pkg::XS_WAIT: begin
                    state <= adv_cfg_pkg::XS_WAIT_2;
                end
                adv_cfg_pkg::XS_WAIT_2: begin
                    if (req.complete) begin
                        // an ack error leaves phase and step alone for a retry
                        state <= adv_cfg_pkg::XS_START;
                        if (!req.ack_error) begin
                            if (pll_phase) begin
                                if (pll_locked) begin
                                    phase <= adv_cfg_pkg::PH_DONE;
                                    ready <= 1'b1;
                                    state <= adv_cfg_pkg::XS_IDLE;
                                end else begin
                                    phase <= adv_cfg_pkg::PH_BOOTSTRAP;
                                end
                            end else if (entry_last) begin
                                phase <= (phase == adv_cfg_pkg::PH_BOOTSTRAP) ?
                                         adv_cfg_pkg::PH_INIT : adv_cfg_pkg::PH_PLL_CHECK;
                            end
                        end
                    end
                end
                adv_cfg_pkg::XS_IDLE: begin
                    if (hdmi_int_pend) begin
                        hdmi_int_pend <= 1'b0;
                        ready         <= 1'b0;
                        phase         <= adv_cfg_pkg::PH_BOOTSTRAP;
                        state         <= adv_cfg_pkg::XS_START;
                    end
                end
                default: begin
                    state <= adv_cfg_pkg::XS_START;
                end
            endcase

            // an edge seen mid sequence is kept until idle
            if (hdmi_int_fall) begin
                hdmi_int_pend <= 1'b1;
            end
        end
    end

    // request payload, loaded together with the issue pulse
    always_ff @(posedge clk) begin
        if (issue_now) begin
            req.is_read  <= pll_phase;
            req.reg_addr <= pll_phase ? adv_cfg_pkg::PLL_STATUS_REG : entry_addr;
            req.value    <= pll_phase ? 8'h00 : entry_value;
        end
    end

endmodule

// File: source/i2c_req_regs.sv
`timescale 1ns/1ps

module i2c_req_regs #(
    parameter adv_cfg_pkg::chip_addr_t CHIP_ADDR = 7'h39
) (
    input  logic                    clk,
    input  logic                    reset,
    i2c_req_if.port                 req,
    input  logic                    i2c_done,
    input  logic                    i2c_ack_error,
    input  adv_cfg_pkg::reg_data_t  i2c_rdata,
    output adv_cfg_pkg::chip_addr_t i2c_chip_addr,
    output adv_cfg_pkg::reg_addr_t  i2c_reg_addr,
    output adv_cfg_pkg::reg_data_t  i2c_value,
    output logic                    i2c_enable,
    output logic                    i2c_is_read
);

    logic strobe_first;
    logic busy;
    logic done_seen;

    // done is stale while enable is up, only trust it afterwards
    assign done_seen = busy && !i2c_enable && i2c_done;

    always_ff @(posedge clk) begin
        if (!reset) begin
            i2c_enable   <= 1'b0;
            strobe_first <= 1'b0;
            busy         <= 1'b0;
            req.complete <= 1'b0;
        end else begin
            req.complete <= 1'b0;
            if (req.issue) begin
                i2c_enable   <= 1'b1;
                strobe_first <= 1'b1;
                busy         <= 1'b1;
            end else if (strobe_first) begin
                // keep enable up for a second cycle
                strobe_first <= 1'b0;
            end else if (i2c_enable) begin
                i2c_enable <= 1'b0;
            end else if (done_seen) begin
                busy         <= 1'b0;
                req.complete <= 1'b1;
            end
        end
    end

    // transaction lines stay put until the next issue
    always_ff @(posedge clk) begin
        if (req.issue) begin
            i2c_chip_addr <= CHIP_ADDR;
            i2c_reg_addr  <= req.reg_addr;
            i2c_value     <= req.value;
            i2c_is_read   <= req.is_read;
        end
        if (done_seen) begin
            req.ack_error <= i2c_ack_error;
            req.rdata     <= i2c_rdata;
        end
    end

endmodule

// File: source/adv_cfg_top.sv
`timescale 1ns/1ps

module adv_cfg_top #(
    parameter adv_cfg_pkg::chip_addr_t CHIP_ADDR      = 7'h39,
    parameter bit                      OUTPUT_FMT_422 = 1'b0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdmi_int,
    input  adv_cfg_pkg::reg_data_t  reg_17,
    input  adv_cfg_pkg::reg_data_t  reg_3b,
    input  adv_cfg_pkg::reg_data_t  reg_3c,
    input  logic                    i2c_done,
    input  logic                    i2c_ack_error,
    input  adv_cfg_pkg::reg_data_t  i2c_rdata,
    output adv_cfg_pkg::chip_addr_t i2c_chip_addr,
    output adv_cfg_pkg::reg_addr_t  i2c_reg_addr,
    output adv_cfg_pkg::reg_data_t  i2c_value,
    output logic                    i2c_enable,
    output logic                    i2c_is_read,
    output logic                    ready,
    output adv_cfg_pkg::err_count_t pll_fail_count
);

    adv_cfg_pkg::phase_t    phase;
    adv_cfg_pkg::step_t     step;
    adv_cfg_pkg::reg_addr_t entry_addr;
    adv_cfg_pkg::reg_data_t entry_value;
    logic                   entry_last;
    logic                   step_advance;
    logic                   step_clear;
    logic                   pll_fail;

    i2c_req_if req_if ();

    adv_cfg_fsm adv_cfg_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .hdmi_int     (hdmi_int),
        .phase        (phase),
        .step         (step),
        .step_advance (step_advance),
        .step_clear   (step_clear),
        .pll_fail     (pll_fail),
        .entry_addr   (entry_addr),
        .entry_value  (entry_value),
        .entry_last   (entry_last),
        .req          (req_if.seq),
        .ready        (ready)
    );

    step_counter step_counter_inst (
        .clk            (clk),
        .reset          (reset),
        .step_advance   (step_advance),
        .step_clear     (step_clear),
        .pll_fail       (pll_fail),
        .step           (step),
        .pll_fail_count (pll_fail_count)
    );

    adv_reg_table #(
        .OUTPUT_FMT_422 (OUTPUT_FMT_422)
    ) adv_reg_table_inst (
        .phase       (phase),
        .step        (step),
        .reg_17      (reg_17),
        .reg_3b      (reg_3b),
        .reg_3c      (reg_3c),
        .entry_addr  (entry_addr),
        .entry_value (entry_value),
        .entry_last  (entry_last)
    );

    i2c_req_regs #(
        .CHIP_ADDR (CHIP_ADDR)
    ) i2c_req_regs_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req_if.port),
        .i2c_done      (i2c_done),
        .i2c_ack_error (i2c_ack_error),
        .i2c_rdata     (i2c_rdata),
        .i2c_chip_addr (i2c_chip_addr),
        .i2c_reg_addr  (i2c_reg_addr),
        .i2c_value     (i2c_value),
        .i2c_enable    (i2c_enable),
        .i2c_is_read   (i2c_is_read)
    );

endmodule

// File: dv/adv_cfg_checker.sv
`timescale 1ns/1ps

module adv_cfg_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic       ready,
    input  logic       i2c_enable,
    input  logic       i2c_is_read,
    input  logic [6:0] i2c_chip_addr,
    input  logic [7:0] i2c_reg_addr,
    input  logic [7:0] i2c_value,
    input  logic       i2c_ack_error,
    input  logic [7:0] i2c_rdata,
    input  logic [7:0] reg_17,
    input  logic [7:0] reg_3b,
    input  logic [7:0] reg_3c,
    output int         errors,
    output int         xfers
);

    // expected position: phase 0 bootstrap, 1 init, 2 PLL status read
    int   exp_ph = 0;
    int   exp_idx = 0;
    logic have_prev = 1'b0;
    logic en_prev = 1'b0;
    logic ready_prev = 1'b0;
    int   en_len = 0;
    int   err_cnt = 0;
    int   xfer_cnt = 0;

    assign errors = err_cnt;
    assign xfers  = xfer_cnt;

    // reference list of register writes, address in the upper byte
    function automatic logic [15:0] expected_write(input int ph, input int idx,
                                                   input logic [7:0] r17,
                                                   input logic [7:0] r3b,
                                                   input logic [7:0] r3c);
        logic [15:0] w;
        w = 16'h0000;
        if (ph == 0) begin
            case (idx)
                0: w = 16'h4110;
                1: w = 16'h9803;
                2: w = 16'h9AE0;
                3: w = 16'h9C30;
                4: w = 16'h9D01;
                5: w = 16'hA2A4;
                6: w = 16'hA3A4;
                7: w = 16'hE0D0;
                8: w = 16'hF900;
                9: w = 16'h94C0;
                10: w = 16'h96C0;
                default: w = 16'h0000;
            endcase
        end else begin
            case (idx)
                0: w = 16'h1500;
                1: w = {8'h17, r17};
                // RGB 4:4:4 output with the default format
                2: w = 16'h1630;
                3: w = 16'h5500;
                4: w = 16'h1846;
                5: w = 16'hAF06;
                6: w = 16'hBA60;
                7: w = 16'h0A00;
                8: w = 16'h0100;
                9: w = 16'h0218;
                10: w = 16'h0380;
                11: w = 16'h0B0E;
                12: w = 16'h0C05;
                13: w = 16'h0D10;
                14: w = {8'h3B, r3b};
                15: w = {8'h3C, r3c};
                default: w = 16'h0000;
            endcase
        end
        return w;
    endfunction

    always @(posedge clk) begin
        int          nph;
        int          nidx;
        int          bad;
        logic [15:0] w;
        bad = 0;
        if (!reset) begin
            exp_ph     <= 0;
            exp_idx    <= 0;
            have_prev  <= 1'b0;
            en_prev    <= 1'b0;
            ready_prev <= 1'b0;
            en_len     <= 0;
        end else begin
            en_prev    <= i2c_enable;
            ready_prev <= ready;
            // enable strobe is exactly two cycles wide
            if (i2c_enable) begin
                if (en_prev) begin
                    en_len <= en_len + 1;
                end else begin
                    en_len <= 1;
                end
            end else if (en_prev && en_len != 2) begin
                $display("ERR %0t: enable high for %0d cycles, expected 2", $time, en_len);
                bad = bad + 1;
            end
            if (i2c_enable && !en_prev) begin
                nph  = exp_ph;
                nidx = exp_idx;
                // result lines still hold the previous transfer here
                if (have_prev && !i2c_ack_error) begin
                    if (nph == 2) begin
                        nph  = 0;
                        nidx = 0;
                    end else if ((nph == 0 && nidx == 10) || (nph == 1 && nidx == 15)) begin
                        nph  = nph + 1;
                        nidx = 0;
                    end else begin
                        nidx = nidx + 1;
                    end
                end
                if (nph == 2) begin
                    if (!i2c_is_read || i2c_reg_addr != 8'h9E) begin
                        $display("ERR %0t: transfer %0d reg %02h read %0b, expected read of 9e",
                                 $time, xfer_cnt + 1, i2c_reg_addr, i2c_is_read);
                        bad = bad + 1;
                    end
                end else begin
                    w = expected_write(nph, nidx, reg_17, reg_3b, reg_3c);
                    if (i2c_is_read || i2c_reg_addr != w[15:8] || i2c_value != w[7:0]) begin
                        $display("ERR %0t: transfer %0d reg %02h value %02h, expected %02h %02h",
                                 $time, xfer_cnt + 1, i2c_reg_addr, i2c_value, w[15:8], w[7:0]);
                        bad = bad + 1;
                    end
                end
                if (i2c_chip_addr != 7'h39) begin
                    $display("ERR %0t: chip address %02h, expected 39", $time, i2c_chip_addr);
                    bad = bad + 1;
                end
                if (ready) begin
                    $display("ERR %0t: ready high during a transfer", $time);
                    bad = bad + 1;
                end
                exp_ph    <= nph;
                exp_idx   <= nidx;
                have_prev <= 1'b1;
                xfer_cnt  <= xfer_cnt + 1;
            end
            // ready may only follow a clean PLL read with the lock bit set
            if (ready && !ready_prev) begin
                if (!have_prev || exp_ph != 2 || i2c_ack_error || !i2c_rdata[4]) begin
                    $display("ERR %0t: ready rose without a locked PLL read", $time);
                    bad = bad + 1;
                end
            end
        end
        err_cnt <= err_cnt + bad;
    end

endmodule

// File: dv/adv_cfg_tb.sv
`timescale 1ns/1ps

module adv_cfg_tb;

    localparam int SEQ_XFERS     = 28;
    localparam int READY_TIMEOUT = 20000;

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    logic [7:0] reg_17;
    logic [7:0] reg_3b;
    logic [7:0] reg_3c;
    logic       i2c_done = 1'b1;
    logic       i2c_ack_error = 1'b0;
    logic [7:0] i2c_rdata = 8'h00;
    logic [6:0] i2c_chip_addr;
    logic [7:0] i2c_reg_addr;
    logic [7:0] i2c_value;
    logic       i2c_enable;
    logic       i2c_is_read;
    logic       ready;
    logic [7:0] pll_fail_count;

    // master model state and its controls from the stimulus
    logic        master_busy = 1'b0;
    int          lat = 0;
    int          xfer_num = 0;
    int          pll_reads = 0;
    int          ack_err_at = -1;
    int          unlock_reads = 0;
    int          errors;
    int          xfers;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned seed;

    adv_cfg_top adv_cfg_top_inst (
        .clk            (clk),
        .reset          (reset),
        .hdmi_int       (hdmi_int),
        .reg_17         (reg_17),
        .reg_3b         (reg_3b),
        .reg_3c         (reg_3c),
        .i2c_done       (i2c_done),
        .i2c_ack_error  (i2c_ack_error),
        .i2c_rdata      (i2c_rdata),
        .i2c_chip_addr  (i2c_chip_addr),
        .i2c_reg_addr   (i2c_reg_addr),
        .i2c_value      (i2c_value),
        .i2c_enable     (i2c_enable),
        .i2c_is_read    (i2c_is_read),
        .ready          (ready),
        .pll_fail_count (pll_fail_count)
    );

    adv_cfg_checker adv_cfg_checker_inst (
        .clk           (clk),
        .reset         (reset),
        .ready         (ready),
        .i2c_enable    (i2c_enable),
        .i2c_is_read   (i2c_is_read),
        .i2c_chip_addr (i2c_chip_addr),
        .i2c_reg_addr  (i2c_reg_addr),
        .i2c_value     (i2c_value),
        .i2c_ack_error (i2c_ack_error),
        .i2c_rdata     (i2c_rdata),
        .reg_17        (reg_17),
        .reg_3b        (reg_3b),
        .reg_3c        (reg_3c),
        .errors        (errors),
        .xfers         (xfers)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // I2C master: drops done after enable, raises it again 2 to 20 cycles later
    always @(posedge clk) begin
        if (!reset) begin
            i2c_done      <= 1'b1;
            i2c_ack_error <= 1'b0;
            master_busy   <= 1'b0;
        end else if (!master_busy) begin
            if (i2c_enable) begin
                master_busy <= 1'b1;
                i2c_done    <= 1'b0;
                lat         <= 2 + int'($urandom % 19);
                xfer_num    <= xfer_num + 1;
            end
        end else if (lat > 0) begin
            lat <= lat - 1;
        end else begin
            master_busy   <= 1'b0;
            i2c_done      <= 1'b1;
            i2c_ack_error <= (xfer_num == ack_err_at);
            if (i2c_is_read && xfer_num != ack_err_at) begin
                // lock bit is bit 4 of the status byte
                i2c_rdata <= (pll_reads < unlock_reads) ? (8'($urandom) & 8'hEF) :
                                                          (8'($urandom) | 8'h10);
                pll_reads <= pll_reads + 1;
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic set_random_config();
        @(posedge clk);
        reg_17 <= 8'($urandom);
        reg_3b <= 8'($urandom);
        reg_3c <= 8'($urandom);
    endtask

    task automatic wait_ready(output bit got);
        int i;
        i = 0;
        while (!ready && i < READY_TIMEOUT) begin
            @(posedge clk);
            i++;
        end
        got = ready;
        if (!got) begin
            $display("timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
        end
    endtask

    task automatic wait_ready_low(output bit dropped);
        int i;
        i = 0;
        // ready is low two cycles after the edge, seen on the third sample
        while (ready && i < 3) begin
            @(posedge clk);
            i++;
        end
        dropped = !ready;
        if (!dropped) begin
            $display("timeout: ready did not fall within two cycles of the hot plug edge");
        end
    endtask

    task automatic report_test(input string name, input bit ok, input int base_e);
        bit pass;
        // let the checker settle its last count
        @(posedge clk);
        pass = ok && (errors == base_e);
        tests_run++;
        if (!pass) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, pass ? "pass" : "fail");
    endtask

    task automatic run_tests();
        int base_x;
        int base_e;
        bit got;
        bit dropped;
        bit ok;

        set_random_config();
        apply_reset();
        base_x = xfers;
        base_e = errors;
        wait_ready(got);
        ok = got && (xfers - base_x == SEQ_XFERS) && (pll_fail_count == 8'd0);
        report_test("bootstrap and init writes", ok, base_e);
        if (!got) return;

        base_x = xfers;
        base_e = errors;
        repeat (300) @(posedge clk);
        ok = ready && (xfers == base_x);
        report_test("idle while ready", ok, base_e);

        // first PLL read after this reset comes back unlocked
        set_random_config();
        unlock_reads <= pll_reads + 1;
        apply_reset();
        base_x = xfers;
        base_e = errors;
        wait_ready(got);
        ok = got && (xfers - base_x == 2 * SEQ_XFERS) && (pll_fail_count == 8'd1);
        report_test("PLL unlock restarts sequence", ok, base_e);
        if (!got) return;

        // sixth transfer is bootstrap step 5
        set_random_config();
        ack_err_at <= xfer_num + 6;
        apply_reset();
        base_x = xfers;
        base_e = errors;
        wait_ready(got);
        ok = got && (xfers - base_x == SEQ_XFERS + 1) && (pll_fail_count == 8'd0);
        report_test("ack error retry", ok, base_e);
        if (!got) return;

        set_random_config();
        base_x = xfers;
        base_e = errors;
        @(posedge clk);
        hdmi_int <= 1'b0;
        wait_ready_low(dropped);
        wait_ready(got);
        @(posedge clk);
        hdmi_int <= 1'b1;
        ok = dropped && got && (xfers - base_x == SEQ_XFERS);
        report_test("hot plug rerun", ok, base_e);
    endtask

    initial begin
        seed = $urandom(32'h84d2);
        reset = 1'b0;
        hdmi_int = 1'b1;
        reg_17 = 8'h00;
        reg_3b = 8'h00;
        reg_3c = 8'h00;
        run_tests();
        $display("tests run %0d, failed %0d, checker errors %0d, transfers %0d",
                 tests_run, tests_failed, errors, xfers);
        if (tests_run == 5 && tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/adv_cfg_pkg.sv
source/i2c_req_if.sv
source/adv_reg_table.sv
source/step_counter.sv
source/adv_cfg_fsm.sv
source/i2c_req_regs.sv
source/adv_cfg_top.sv
dv/adv_cfg_checker.sv
dv/adv_cfg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module adv_cfg_tb --Mdir obj_dir -o adv_cfg_sim \
    -f list.f
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/adv_cfg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "run passed"
    exit 0
else
    echo "run failed, see $LOG"
    exit 1
fi
